//--- hw/ppu_obj_pkg.sv
package ppu_obj_pkg;

  localparam int SCREEN_W    = 160;
  localparam int OAM_ENTRIES = 40;

  // colour 0 is transparent
  typedef logic [1:0] color_id_t;

  // attr bits: 7 bg priority, 6 y-flip, 5 x-flip, 4 palette
  typedef struct packed {
    logic [7:0] y_pos;
    logic [7:0] x_pos;
    logic [7:0] tile_idx;
    logic [7:0] attr;
    logic       valid;
  } obj_entry_t;

  typedef struct packed {
    color_id_t  color;
    logic       palette;
    logic       bg_prio;
    logic [5:0] oam_idx;
  } obj_pixel_t;

  typedef struct packed {
    logic [7:0] ly;
    // set for 8x16 objects
    logic       tall;
  } line_cfg_t;

  typedef struct packed {
    logic [5:0] idx;
    obj_entry_t entry;
  } oam_wr_t;

  // addr is an offset from 0x8000
  typedef struct packed {
    logic [12:0] addr;
    logic [7:0]  data;
  } tile_wr_t;

  typedef enum logic [1:0] {LINE_IDLE, LINE_SCAN, LINE_DRAW} line_state_t;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_LOW, FETCH_HIGH, FETCH_PUSH} fetch_state_t;

endpackage

//--- hw/oam_scan.sv
`timescale 1ns/100ps

module oam_scan #(
  parameter int MAX_SPRITES = 10
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    oam_wr_en,
  input  ppu_obj_pkg::oam_wr_t    oam_wr,
  input  logic                    scan_start,
  input  ppu_obj_pkg::line_cfg_t  line_cfg,
  output ppu_obj_pkg::obj_entry_t sprite_buf [MAX_SPRITES],
  output logic [5:0]              sprite_oam_idx [MAX_SPRITES],
  output ppu_obj_pkg::line_cfg_t  scan_cfg,
  output logic                    scan_done
);

  localparam int CNT_W = $clog2(MAX_SPRITES + 1);

  ppu_obj_pkg::obj_entry_t oam [ppu_obj_pkg::OAM_ENTRIES];
  logic [ppu_obj_pkg::OAM_ENTRIES-1:0] oam_valid;

  ppu_obj_pkg::obj_entry_t buf_entry [MAX_SPRITES];
  logic [MAX_SPRITES-1:0]  buf_valid;

  logic             scanning;
  logic [5:0]       scan_idx;
  logic [CNT_W-1:0] fill_cnt;
  logic             wr_ok;
  logic             take;
  ppu_obj_pkg::obj_entry_t cand;
  logic [8:0]       ly16;
  logic [8:0]       y_end;
  logic             hit;

  // OAM is frozen while the scan walks it
  assign wr_ok = oam_wr_en && !scanning && (oam_wr.idx < 6'(ppu_obj_pkg::OAM_ENTRIES));

  // line test on ly+16 so no negative y is needed
  always_comb begin
    cand  = oam[scan_idx];
    ly16  = {1'b0, scan_cfg.ly} + 9'd16;
    y_end = {1'b0, cand.y_pos} + (scan_cfg.tall ? 9'd16 : 9'd8);
    hit   = oam_valid[scan_idx] && (ly16 >= {1'b0, cand.y_pos}) && (ly16 < y_end) &&
            (cand.x_pos >= 8'd8) && (cand.x_pos < 8'd168);
  end

  assign take = scanning && hit && (fill_cnt < CNT_W'(MAX_SPRITES));

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      oam[oam_wr.idx] <= oam_wr.entry;
    end
    if (scan_start) begin
      scan_cfg <= line_cfg;
    end
    if (take) begin
      buf_entry[fill_cnt]      <= cand;
      sprite_oam_idx[fill_cnt] <= scan_idx;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      oam_valid <= '0;
      scanning  <= 1'b0;
      scan_idx  <= '0;
      fill_cnt  <= '0;
      buf_valid <= '0;
      scan_done <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      if (wr_ok) begin
        oam_valid[oam_wr.idx] <= oam_wr.entry.valid;
      end
      if (scan_start) begin
        scanning  <= 1'b1;
        scan_idx  <= '0;
        fill_cnt  <= '0;
        buf_valid <= '0;
      end else if (scanning) begin
        if (take) begin
          buf_valid[fill_cnt] <= 1'b1;
          fill_cnt            <= fill_cnt + 1'b1;
        end
        if (scan_idx == 6'(ppu_obj_pkg::OAM_ENTRIES - 1)) begin
          scanning  <= 1'b0;
          scan_done <= 1'b1;
        end else begin
          scan_idx <= scan_idx + 6'd1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < MAX_SPRITES; i++) begin
      sprite_buf[i]       = buf_entry[i];
      sprite_buf[i].valid = buf_valid[i];
    end
  end

endmodule

//--- hw/line_timing.sv
`timescale 1ns/100ps

module line_timing (
  input  logic       clk,
  input  logic       reset,
  input  logic       line_start,
  input  logic       hold,
  output logic       busy,
  output logic       scan_start,
  output logic       drawing,
  output logic [7:0] x,
  output logic       shift,
  output logic       pix_valid,
  output logic       line_done
);

  // 40 entry visits plus the scan_done cycle
  localparam logic [5:0] SCAN_LAST = 6'(ppu_obj_pkg::OAM_ENTRIES);
  localparam logic [7:0] X_LAST    = 8'(ppu_obj_pkg::SCREEN_W - 1);

  ppu_obj_pkg::line_state_t state;
  logic [5:0] scan_cnt;

  assign busy       = (state != ppu_obj_pkg::LINE_IDLE);
  assign drawing    = (state == ppu_obj_pkg::LINE_DRAW);
  // a line start is only taken while idle
  assign scan_start = line_start && (state == ppu_obj_pkg::LINE_IDLE);
  assign shift      = drawing && !hold;
  assign pix_valid  = shift;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= ppu_obj_pkg::LINE_IDLE;
      scan_cnt  <= '0;
      x         <= '0;
      line_done <= 1'b0;
    end else begin
      line_done <= 1'b0;
      case (state)
        ppu_obj_pkg::LINE_IDLE: begin
          if (scan_start) begin
            state    <= ppu_obj_pkg::LINE_SCAN;
            scan_cnt <= '0;
            x        <= '0;
          end
        end
        ppu_obj_pkg::LINE_SCAN: begin
          if (scan_cnt == SCAN_LAST) begin
            state <= ppu_obj_pkg::LINE_DRAW;
          end else begin
            scan_cnt <= scan_cnt + 6'd1;
          end
        end
        ppu_obj_pkg::LINE_DRAW: begin
          if (!hold) begin
            if (x == X_LAST) begin
              state     <= ppu_obj_pkg::LINE_IDLE;
              line_done <= 1'b1;
            end else begin
              x <= x + 8'd1;
            end
          end
        end
        default: state <= ppu_obj_pkg::LINE_IDLE;
      endcase
    end
  end

endmodule

//--- hw/obj_fetcher.sv
`timescale 1ns/100ps

module obj_fetcher #(
  parameter int MAX_SPRITES = 10,
  parameter int TILE_ADDR_W = 13
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    scan_done,
  input  logic                    drawing,
  input  logic [7:0]              x,
  input  ppu_obj_pkg::line_cfg_t  line_cfg,
  input  ppu_obj_pkg::obj_entry_t sprite_buf [MAX_SPRITES],
  input  logic [5:0]              sprite_oam_idx [MAX_SPRITES],
  input  logic                    rd_ack,
  input  logic [7:0]              rd_data,
  output logic                    hold,
  output logic                    rd_req,
  output logic [TILE_ADDR_W-1:0]  rd_addr,
  output logic                    merge_en,
  output ppu_obj_pkg::obj_pixel_t merge_pix [8]
);

  localparam int IDX_W = (MAX_SPRITES > 1) ? $clog2(MAX_SPRITES) : 1;

  ppu_obj_pkg::fetch_state_t state;
  ppu_obj_pkg::obj_entry_t   cur;
  ppu_obj_pkg::obj_pixel_t   built [8];

  logic [MAX_SPRITES-1:0] pend;
  logic [MAX_SPRITES-1:0] hit;
  logic [IDX_W-1:0]       sel_idx;
  logic                   any_hit;
  logic [5:0]             cur_oam;
  logic [7:0]             lo_byte;
  logic [7:0]             hi_byte;
  logic [7:0]             row_raw;
  logic [3:0]             row;
  logic [7:0]             tile;
  logic [2:0]             bit_sel;
  logic                   rd_free;

  // lowest buffer index wins when several start at this x
  always_comb begin
    sel_idx = '0;
    for (int i = 0; i < MAX_SPRITES; i++) begin
      hit[i] = pend[i] && ((sprite_buf[i].x_pos - 8'd8) == x);
    end
    for (int i = MAX_SPRITES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel_idx = IDX_W'(i);
      end
    end
  end

  assign any_hit = |hit;
  // merge cycle also stalls so the FIFO never merges and shifts together
  assign hold    = drawing && (any_hit || (state != ppu_obj_pkg::FETCH_IDLE) || merge_en);
  assign rd_free = !rd_req && !rd_ack;

  // row inside the object, tall objects span two tiles
  always_comb begin
    row_raw = line_cfg.ly + 8'd16 - cur.y_pos;
    row     = row_raw[3:0];
    if (cur.attr[6]) begin
      row = line_cfg.tall ? (4'd15 - row) : (4'd7 - {1'b0, row[2:0]});
    end
    tile = line_cfg.tall ? {cur.tile_idx[7:1], row[3]} : cur.tile_idx;
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      bit_sel = cur.attr[5] ? 3'(i) : 3'(7 - i);
      built[i].color   = {hi_byte[bit_sel], lo_byte[bit_sel]};
      built[i].palette = cur.attr[4];
      built[i].bg_prio = cur.attr[7];
      built[i].oam_idx = cur_oam;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ppu_obj_pkg::FETCH_IDLE && drawing && any_hit) begin
      cur     <= sprite_buf[sel_idx];
      cur_oam <= sprite_oam_idx[sel_idx];
    end
    if (rd_free && state == ppu_obj_pkg::FETCH_LOW) begin
      rd_addr <= TILE_ADDR_W'({tile, row[2:0], 1'b0});
    end
    if (rd_free && state == ppu_obj_pkg::FETCH_HIGH) begin
      rd_addr <= TILE_ADDR_W'({tile, row[2:0], 1'b1});
    end
    if (rd_req && rd_ack && state == ppu_obj_pkg::FETCH_LOW) begin
      lo_byte <= rd_data;
    end
    if (rd_req && rd_ack && state == ppu_obj_pkg::FETCH_HIGH) begin
      hi_byte <= rd_data;
    end
    if (state == ppu_obj_pkg::FETCH_PUSH) begin
      merge_pix <= built;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= ppu_obj_pkg::FETCH_IDLE;
      pend     <= '0;
      rd_req   <= 1'b0;
      merge_en <= 1'b0;
    end else begin
      merge_en <= 1'b0;
      if (scan_done) begin
        for (int i = 0; i < MAX_SPRITES; i++) begin
          pend[i] <= sprite_buf[i].valid;
        end
      end
      case (state)
        ppu_obj_pkg::FETCH_IDLE: begin
          if (drawing && any_hit) begin
            pend[sel_idx] <= 1'b0;
            state         <= ppu_obj_pkg::FETCH_LOW;
          end
        end
        ppu_obj_pkg::FETCH_LOW, ppu_obj_pkg::FETCH_HIGH: begin
          if (rd_free) begin
            rd_req <= 1'b1;
          end else if (rd_req && rd_ack) begin
            rd_req <= 1'b0;
            state  <= (state == ppu_obj_pkg::FETCH_LOW) ? ppu_obj_pkg::FETCH_HIGH :
                                                          ppu_obj_pkg::FETCH_PUSH;
          end
        end
        ppu_obj_pkg::FETCH_PUSH: begin
          merge_en <= 1'b1;
          state    <= ppu_obj_pkg::FETCH_IDLE;
        end
        default: state <= ppu_obj_pkg::FETCH_IDLE;
      endcase
    end
  end

endmodule

//--- hw/tile_mem.sv
`timescale 1ns/100ps

module tile_mem #(
  parameter int TILE_ADDR_W = 13
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   tile_wr_en,
  input  ppu_obj_pkg::tile_wr_t  tile_wr,
  input  logic                   rd_req,
  input  logic [TILE_ADDR_W-1:0] rd_addr,
  output logic                   rd_ack,
  output logic [7:0]             rd_data
);

  logic [7:0] mem [2**TILE_ADDR_W];

  always_ff @(posedge clk) begin
    if (tile_wr_en) begin
      mem[TILE_ADDR_W'(tile_wr.addr)] <= tile_wr.data;
    end
    // data is ready together with ack
    if (rd_req && !rd_ack) begin
      rd_data <= mem[rd_addr];
    end
  end

  // four-phase responder, ack follows req one cycle behind
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ack <= 1'b0;
    end else if (rd_req && !rd_ack) begin
      rd_ack <= 1'b1;
    end else if (!rd_req && rd_ack) begin
      rd_ack <= 1'b0;
    end
  end

endmodule

//--- hw/obj_pixel_fifo.sv
`timescale 1ns/100ps

module obj_pixel_fifo (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    shift,
  input  logic                    merge_en,
  input  ppu_obj_pkg::obj_pixel_t merge_pix [8],
  input  logic                    line_start,
  output ppu_obj_pkg::obj_pixel_t head
);

  localparam ppu_obj_pkg::obj_pixel_t CLEAR_PIX = '0;

  ppu_obj_pkg::obj_pixel_t slots [8];
  ppu_obj_pkg::obj_pixel_t slots_nxt [8];

  // slot 0 is the next pixel out
  assign head = slots[0];

  always_comb begin
    slots_nxt = slots;
    if (merge_en) begin
      // only fill holes, pixels already there keep priority
      for (int i = 0; i < 8; i++) begin
        if (slots[i].color == 2'd0 && merge_pix[i].color != 2'd0) begin
          slots_nxt[i] = merge_pix[i];
        end
      end
    end
    if (shift) begin
      for (int i = 0; i < 7; i++) begin
        slots_nxt[i] = slots_nxt[i + 1];
      end
      slots_nxt[7] = CLEAR_PIX;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        slots[i] <= CLEAR_PIX;
      end
    end else if (line_start) begin
      for (int i = 0; i < 8; i++) begin
        slots[i] <= CLEAR_PIX;
      end
    end else begin
      slots <= slots_nxt;
    end
  end

endmodule

//--- hw/obj_line_top.sv
`timescale 1ns/100ps

module obj_line_top #(
  parameter int MAX_SPRITES = 10,
  parameter int TILE_ADDR_W = 13
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    oam_wr_en,
  input  ppu_obj_pkg::oam_wr_t    oam_wr,
  input  logic                    tile_wr_en,
  input  ppu_obj_pkg::tile_wr_t   tile_wr,
  input  logic                    line_start,
  input  ppu_obj_pkg::line_cfg_t  line_cfg,
  output logic                    pix_valid,
  output ppu_obj_pkg::obj_pixel_t pix,
  output logic                    busy,
  output logic                    line_done
);

  ppu_obj_pkg::obj_entry_t sprite_buf [MAX_SPRITES];
  logic [5:0]              sprite_oam_idx [MAX_SPRITES];
  ppu_obj_pkg::line_cfg_t  scan_cfg;
  ppu_obj_pkg::obj_pixel_t merge_pix [8];

  logic                   scan_start;
  logic                   scan_done;
  logic                   drawing;
  logic [7:0]             x;
  logic                   hold;
  logic                   shift;
  logic                   rd_req;
  logic                   rd_ack;
  logic [TILE_ADDR_W-1:0] rd_addr;
  logic [7:0]             rd_data;
  logic                   merge_en;

  oam_scan #(.MAX_SPRITES(MAX_SPRITES)) i_oam_scan (
    .clk(clk), .reset(reset), .oam_wr_en(oam_wr_en), .oam_wr(oam_wr),
    .scan_start(scan_start), .line_cfg(line_cfg), .sprite_buf(sprite_buf),
    .sprite_oam_idx(sprite_oam_idx), .scan_cfg(scan_cfg), .scan_done(scan_done)
  );

  line_timing i_line_timing (
    .clk(clk), .reset(reset), .line_start(line_start), .hold(hold), .busy(busy),
    .scan_start(scan_start), .drawing(drawing), .x(x), .shift(shift),
    .pix_valid(pix_valid), .line_done(line_done)
  );

  obj_fetcher #(.MAX_SPRITES(MAX_SPRITES), .TILE_ADDR_W(TILE_ADDR_W)) i_obj_fetcher (
    .clk(clk), .reset(reset), .scan_done(scan_done), .drawing(drawing), .x(x),
    .line_cfg(scan_cfg), .sprite_buf(sprite_buf), .sprite_oam_idx(sprite_oam_idx),
    .rd_ack(rd_ack), .rd_data(rd_data), .hold(hold), .rd_req(rd_req),
    .rd_addr(rd_addr), .merge_en(merge_en), .merge_pix(merge_pix)
  );

  tile_mem #(.TILE_ADDR_W(TILE_ADDR_W)) i_tile_mem (
    .clk(clk), .reset(reset), .tile_wr_en(tile_wr_en), .tile_wr(tile_wr),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data)
  );

  // cleared on the accepted line start only
  obj_pixel_fifo i_obj_pixel_fifo (
    .clk(clk), .reset(reset), .shift(shift), .merge_en(merge_en),
    .merge_pix(merge_pix), .line_start(scan_start), .head(pix)
  );

endmodule

//--- sim/obj_line_asserts.sv
`timescale 1ns/100ps

module obj_line_asserts (
  input logic clk,
  input logic reset,
  input logic rd_req,
  input logic rd_ack,
  input logic pix_valid,
  input logic line_done
);

  // four-phase read holds req until acknowledged
  req_held: assert property (@(posedge clk) disable iff (reset)
    rd_req && !rd_ack |=> rd_req)
    else $error("rd_req dropped before rd_ack");

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(rd_ack) |-> $past(rd_req))
    else $error("rd_ack rose without rd_req");

  // dot counter stays stalled while a tile read is open
  no_pix_during_read: assert property (@(posedge clk) disable iff (reset)
    (rd_req || rd_ack) |-> !pix_valid)
    else $error("pix_valid high during a tile read");

  done_one_cycle: assert property (@(posedge clk) disable iff (reset)
    line_done |=> !line_done)
    else $error("line_done longer than one cycle");

endmodule

bind obj_line_top obj_line_asserts i_obj_line_asserts (
  .clk(clk), .reset(reset), .rd_req(rd_req), .rd_ack(rd_ack),
  .pix_valid(pix_valid), .line_done(line_done)
);

//--- sim/obj_line_tb.sv
`timescale 1ns/100ps

module obj_line_tb;

  localparam int    PIX_LINE  = ppu_obj_pkg::SCREEN_W;
  localparam string DATA_FILE = "sim/obj_line_testdata.txt";

  logic                    clk;
  logic                    reset;
  logic                    oam_wr_en;
  ppu_obj_pkg::oam_wr_t    oam_wr;
  logic                    tile_wr_en;
  ppu_obj_pkg::tile_wr_t   tile_wr;
  logic                    line_start;
  ppu_obj_pkg::line_cfg_t  line_cfg;
  logic                    pix_valid;
  ppu_obj_pkg::obj_pixel_t pix;
  logic                    busy;
  logic                    line_done;

  // parsed records, replayed in file order
  byte                     kind_q [$];
  logic [39:0]             arg_q [$];
  ppu_obj_pkg::obj_pixel_t exp_q [$];

  int seed = 31614;
  int cycles;
  int cycle_limit;
  int line_count;
  int lines_finished;
  int pix_count;

  obj_line_top #(.MAX_SPRITES(10), .TILE_ADDR_W(13)) i_obj_line_top (
    .clk(clk), .reset(reset), .oam_wr_en(oam_wr_en), .oam_wr(oam_wr),
    .tile_wr_en(tile_wr_en), .tile_wr(tile_wr), .line_start(line_start),
    .line_cfg(line_cfg), .pix_valid(pix_valid), .pix(pix), .busy(busy),
    .line_done(line_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_pixel(input ppu_obj_pkg::obj_pixel_t got,
                             input ppu_obj_pkg::obj_pixel_t exp, input int x_pos);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] t=%0t pix (x=%0d) got=%03h exp=%03h",
                               $time, x_pos, got, exp));
    end
  endtask

  task automatic check_done(input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("[FAIL] t=%0t pixel count at line_done got=%0d exp=%0d",
                               $time, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] t=%0t %s got=%b exp=%b", $time, name, got, exp));
    end
  endtask

  task automatic read_testdata();
    int fd;
    int code;
    int n;
    int a;
    int b;
    int c;
    int d;
    int e;
    int p;
    string rest;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      report_failure("could not open the test data file");
    end
    code = $fgetc(fd);
    while (code != -1) begin
      if (code == "#") begin
        n = $fgets(rest, fd);
      end else if (code == "O") begin
        n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
        if (n != 5) report_failure("malformed OAM record in test data");
        kind_q.push_back("O");
        arg_q.push_back({a[7:0], b[7:0], c[7:0], d[7:0], e[7:0]});
      end else if (code == "T") begin
        n = $fscanf(fd, "%h %h", a, b);
        if (n != 2) report_failure("malformed tile record in test data");
        kind_q.push_back("T");
        arg_q.push_back({16'd0, a[15:0], b[7:0]});
      end else if (code == "L") begin
        n = $fscanf(fd, "%h %h", a, b);
        if (n != 2) report_failure("malformed line record in test data");
        kind_q.push_back("L");
        arg_q.push_back({24'd0, a[7:0], 7'd0, b[0]});
        for (int i = 0; i < PIX_LINE; i++) begin
          n = $fscanf(fd, "%h", p);
          if (n != 1) report_failure("test data ended inside a pixel row");
          exp_q.push_back(ppu_obj_pkg::obj_pixel_t'(p[9:0]));
        end
        line_count++;
      end else if (code != " " && code != "\n" && code != "\r" && code != "\t") begin
        report_failure($sformatf("unknown record kind '%c' in test data", code));
      end
      code = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic write_oam(input logic [39:0] arg);
    @(negedge clk);
    oam_wr_en             = 1'b1;
    oam_wr.idx            = arg[37:32];
    oam_wr.entry.y_pos    = arg[31:24];
    oam_wr.entry.x_pos    = arg[23:16];
    oam_wr.entry.tile_idx = arg[15:8];
    oam_wr.entry.attr     = arg[7:0];
    oam_wr.entry.valid    = 1'b1;
    @(negedge clk);
    oam_wr_en = 1'b0;
  endtask

  task automatic write_tile(input logic [39:0] arg);
    @(negedge clk);
    tile_wr_en   = 1'b1;
    tile_wr.addr = arg[20:8];
    tile_wr.data = arg[7:0];
    @(negedge clk);
    tile_wr_en = 1'b0;
  endtask

  task automatic run_line(input logic [39:0] arg);
    int pause;
    int target;
    pause  = $unsigned($random(seed)) % 6;
    target = lines_finished + 1;
    repeat (pause) @(negedge clk);
    check_flag("busy", busy, 1'b0);
    line_cfg.ly   = arg[15:8];
    line_cfg.tall = arg[0];
    line_start    = 1'b1;
    @(negedge clk);
    line_start = 1'b0;
    check_flag("busy", busy, 1'b1);
    // a stray start in mid-line is ignored
    repeat (20) @(negedge clk);
    line_cfg   = '0;
    line_start = 1'b1;
    @(negedge clk);
    line_start = 1'b0;
    wait (lines_finished == target);
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
  endtask

  // one expected pixel per advancing dot in x order
  always @(posedge clk) begin
    if (!reset && pix_valid) begin
      if (exp_q.size() == 0) begin
        report_failure("a pixel came out with no expected pixel left");
      end else begin
        check_pixel(pix, exp_q.pop_front(), pix_count);
        pix_count++;
      end
    end
    if (!reset && line_done) begin
      check_done(pix_count, PIX_LINE);
      pix_count = 0;
      lines_finished++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  initial begin
    logic [39:0] arg;
    byte         kind;
    reset      = 1'b1;
    oam_wr_en  = 1'b0;
    oam_wr     = '0;
    tile_wr_en = 1'b0;
    tile_wr    = '0;
    line_start = 1'b0;
    line_cfg   = '0;
    cycle_limit = 100000;
    read_testdata();
    // scan, dots and up to ten fetches per line plus two cycles per load
    cycle_limit = line_count * (60 + PIX_LINE + 10 * 12) + 2 * kind_q.size() + 100;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    while (kind_q.size() > 0) begin
      kind = kind_q.pop_front();
      arg  = arg_q.pop_front();
      case (kind)
        "O": write_oam(arg);
        "T": write_tile(arg);
        default: run_line(arg);
      endcase
    end
    repeat (2) @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- sim/obj_line_testdata.txt
# O idx y x tile attr | T addr data | L ly tall, then 160 expected pixels (all hex)
# pixel = {color[1:0], palette, bg_prio, oam_idx[5:0]}, 000 is transparent
# line A: plain, x-flip, y-flip with bg priority, x 4 and x 168 hidden
O 00 24 10 01 00
O 01 24 28 01 30
O 02 1f 3c 01 c0
O 03 24 04 01 00
O 04 24 a8 01 00
T 0010 f0
T 0011 cc
T 0014 81
T 0015 18
L 14 0
000 000 000 000 000 000 000 000 300 300 100 100 200 200 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 281 281 181 181 381 381
000 000 000 000 000 000 000 000 000 000 000 000 142 000 000 242 242 000 000 142
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
# line B: 8x16, tile bit 0 ignored, lower tile on rows 8 to 15, flips
O 05 3e 18 03 00
O 06 38 30 02 20
O 07 3c 48 03 50
T 0028 0f
T 0029 3c
T 0034 a0
T 0035 60
T 0032 55
T 0033 ff
L 32 1
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 205 205
305 305 105 105 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 306 206 106 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 287 387 287 387 287 387 287 387 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
# line C: overlap, same-x tie, ten-sprite limit, entries 0c and 0d hidden
O 08 6a 14 04 00
O 09 6a 17 05 00
O 0a 6a 28 04 00
O 0b 6a 28 05 00
O 0c 6a 00 05 00
O 0d 6a a8 05 00
O 0e 6a 38 05 00
O 0f 6a 44 05 00
O 10 6a 50 05 00
O 11 6a 5c 05 00
O 12 6a 68 05 00
O 13 6a 74 05 00
O 14 6a 80 05 00
O 15 6a 8c 05 00
T 0040 aa
T 0041 00
T 0050 ff
T 0051 ff
L 5a 0
000 000 000 000 000 000 000 000 000 000 000 000 108 000 108 309 108 309 108 309
309 309 309 000 000 000 000 000 000 000 000 000 10a 30b 10a 30b 10a 30b 10a 30b
000 000 000 000 000 000 000 000 30e 30e 30e 30e 30e 30e 30e 30e 000 000 000 000
30f 30f 30f 30f 30f 30f 30f 30f 000 000 000 000 310 310 310 310 310 310 310 310
000 000 000 000 311 311 311 311 311 311 311 311 000 000 000 000 312 312 312 312
312 312 312 312 000 000 000 000 313 313 313 313 313 313 313 313 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000

//--- sim.f
hw/ppu_obj_pkg.sv
hw/oam_scan.sv
hw/line_timing.sv
hw/obj_fetcher.sv
hw/tile_mem.sv
hw/obj_pixel_fifo.sv
hw/obj_line_top.sv
sim/obj_line_asserts.sv
sim/obj_line_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the object line testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing --assert -Wno-fatal --top-module obj_line_tb \
  -f sim.f -o obj_line_sim > "$log" 2>&1 && ./obj_dir/obj_line_sim >> "$log" 2>&1
grep -qF '*** TEST FAILED ***' "$log" && { echo "simulation failed, see $log"; exit 1; }
grep -qF '*** TEST PASSED ***' "$log" || { echo "no pass result in $log"; exit 1; }
echo "simulation passed"
